// ==== list.f ====
noc_pkg.sv
input_queue.sv
route_calc.sv
switch_control.sv
crossbar.sv
router_top.sv
tb_router_assert.sv
tb_router.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the router testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module tb_router \
  -f list.f -o tb_router_sim

# The simulation log decides the result
./obj_dir/tb_router_sim | tee sim.log

if grep -q "^Regression passed$" sim.log; then
  exit 0
else
  exit 1
fi

// ==== router_stim.txt ====
# phase port x_dest y_dest payload en_mask   (port 0..4 = core north east south west)
# phases: 1 latency, 2 routing, 3 back-pressure, 4 contention, 5 random i_en
1 0 3 2 1001 1f
1 1 2 0 1002 1f
1 2 2 3 1003 1f
1 3 0 1 1004 1f
1 4 2 2 1005 1f
1 0 9 1 1006 1f
1 2 1 f 1007 1f
2 0 3 1 2001 1f
2 0 3 3 2002 1f
2 1 2 3 2003 1f
2 1 2 3 2004 1f
2 2 0 0 2005 1f
2 3 2 0 2006 1f
2 4 2 2 2007 1f
2 4 f f 2008 1f
# east output held low while the core queue fills
3 0 3 2 3001 1b
3 0 3 0 3002 1b
3 0 3 3 3003 1b
3 0 3 1 3004 1b
# north and south both aim at west, west held until all are queued
4 1 0 2 4001 0f
4 3 0 1 4002 0f
4 1 1 3 4003 0f
4 3 0 0 4004 0f
4 1 1 1 4005 0f
4 3 0 3 4006 0f
5 0 3 0 5001 1f
5 1 0 2 5002 1f
5 2 2 0 5003 1f
5 3 2 3 5004 1f
5 4 2 2 5005 1f
5 0 1 1 5006 1f
5 2 3 3 5007 1f
5 4 0 0 5008 1f

// ==== tb_router.sv ====
`timescale 1ns/100ps

module tb_router
  import noc_pkg::*;
();

  localparam integer CLK_PERIOD = 100;
  localparam integer TIMEOUT    = 200;  // Cycles per wait loop
  localparam integer X_NODES    = 4;
  localparam integer Y_NODES    = 4;
  localparam integer X_LOC      = 2;
  localparam integer Y_LOC      = 2;
  localparam integer DEPTH      = 4;

  logic                  clk;
  logic                  reset_n;
  packet_t [0:N_PORTS-1] i_data;
  logic    [0:N_PORTS-1] i_data_val;
  logic    [0:N_PORTS-1] o_en;
  packet_t [0:N_PORTS-1] o_data;
  logic    [0:N_PORTS-1] o_data_val;
  logic    [0:N_PORTS-1] i_en;

  int      st_phase[$];                // Phase of each stimulus line
  int      st_port[$];                 // Injection port
  int      st_x[$];                    // Destination column
  int      st_y[$];                    // Destination row
  int      st_pay[$];                  // Payload
  int      st_mask[$];                 // Downstream enable mask
  // Expected packets, indexed by input * N_PORTS + output
  packet_t exp_q[N_PORTS*N_PORTS][$];
  int      acc_q[N_PORTS*N_PORTS][$];  // Acceptance cycle of each expected packet
  int      seen_src[$];                // Source order on the watched output
  int      pending      = 0;
  int      errors       = 0;
  int      test_errors  = 0;
  int      tests_run    = 0;
  int      tests_failed = 0;
  int      cyc          = 0;
  int      watch_out    = -1;
  logic    mon_on       = 1'b0;
  logic    lat_mode     = 1'b0;  // Check one-cycle latency
  logic    stress_mode  = 1'b0;  // Random i_en while injecting
  logic [31:0] lcg_state = 32'd66074;

  router_top #(.X_NODES(X_NODES), .Y_NODES(Y_NODES), .X_LOC(X_LOC), .Y_LOC(Y_LOC),
               .DEPTH(DEPTH)) router_top_i (
    .clk,
    .reset_n,
    .i_data,
    .i_data_val,
    .o_en,
    .o_data,
    .o_data_val,
    .i_en
  );

  bind router_top tb_router_assert tb_router_assert_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_en       (i_en),
    .o_data_val (o_data_val),
    .i_grant    (output_grant)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;  // Cycle stamp for latency

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  // Dimension-order rule with X before Y and strays sent to core
  function automatic int expected_port(input int x, input int y);
    if (x >= X_NODES || y >= Y_NODES) return int'(CORE);
    if (x > X_LOC) return int'(EAST);
    if (x < X_LOC) return int'(WEST);
    if (y > Y_LOC) return int'(SOUTH);
    if (y < Y_LOC) return int'(NORTH);
    return int'(CORE);
  endfunction

  function automatic logic [4:0] random_mask();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[20:16];  // Upper bits spread better than the low ones
  endfunction

  task automatic set_en(input logic [4:0] mask);
    for (int p = 0; p < N_PORTS; p++) i_en[p] = mask[p];  // Bit p drives port p
  endtask

  // Offer one packet, wait for acceptance and book it in the scoreboard
  task automatic inject_packet(input int port, input int x, input int y, input int pay);
    packet_t pkt;
    int      waited;
    int      key;
    logic    accepted;
    pkt.x_dest   = COORD_W'(x);
    pkt.y_dest   = COORD_W'(y);
    pkt.src_port = port_e'(port);
    pkt.payload  = PAYLOAD_W'(pay);
    key          = port * N_PORTS + expected_port(x, y);
    waited       = 0;
    accepted     = 1'b0;
    @(negedge clk);
    if (stress_mode) set_en(random_mask());
    i_data[port]     = pkt;
    i_data_val[port] = 1'b1;
    while (!accepted && waited < TIMEOUT) begin
      #(CLK_PERIOD/4);
      if (o_en[port]) begin  // Transfer at the coming rising edge
        exp_q[key].push_back(pkt);
        acc_q[key].push_back(cyc);
        pending++;
        accepted = 1'b1;
      end
      @(negedge clk);
      waited++;
      if (stress_mode) set_en(random_mask());
    end
    i_data_val[port] = 1'b0;
    if (!accepted) begin
      $display("Packet with payload %h was never accepted on port %0d", pay, port);
      errors++;
      test_errors++;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (pending > 0 && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (pending > 0) begin
      for (int k = 0; k < N_PORTS * N_PORTS; k++) begin
        if (exp_q[k].size() > 0)
          $display("Packet with payload %h from port %0d to port %0d never arrived",
                   exp_q[k][0].payload, k / N_PORTS, k % N_PORTS);
        exp_q[k].delete();
        acc_q[k].delete();
      end
      errors++;
      test_errors++;
      pending = 0;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) $display("Test %-13s done, no errors", name);
    else begin
      $display("Test %-13s done, %0d errors", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  // --------------------------------------------------------------------------
  // Output monitor sampling a quarter period after the falling edge
  // --------------------------------------------------------------------------

  always begin : monitor
    int      src;
    int      key;
    int      acc;
    packet_t exp_pkt;
    @(negedge clk);
    #(CLK_PERIOD/4);
    for (int o = 0; o < N_PORTS && mon_on; o++) begin
      if (o_data_val[o]) begin
        check_value($sformatf("i_en[%0d] with o_data_val", o), 1, i_en[o]);
        src = int'(o_data[o].src_port);
        key = src * N_PORTS + o;
        if (exp_q[key].size() == 0) begin
          $display("Unexpected packet %h on output %0d", o_data[o], o);
          errors++;
          test_errors++;
        end else begin
          exp_pkt = exp_q[key].pop_front();
          acc     = acc_q[key].pop_front();
          pending--;
          check_value($sformatf("o_data[%0d]", o), exp_pkt, o_data[o]);
          if (lat_mode) check_value("latency in cycles", 1, cyc - acc);
          if (o == watch_out) seen_src.push_back(src);
        end
      end
    end
  end

  // Runs every stimulus line of one phase
  task automatic run_phase(input int phase, input string name);
    logic first;
    int   bp_port;
    int   n_lines;
    first   = 1'b1;
    bp_port = 0;
    n_lines = 0;
    seen_src.delete();
    lat_mode    = (phase == 1);
    stress_mode = (phase == 5);
    for (int i = 0; i < st_phase.size(); i++) begin
      if (st_phase[i] == phase) begin
        if (first) begin
          @(negedge clk);
          set_en(5'(st_mask[i]));
          bp_port   = st_port[i];
          watch_out = (phase == 4) ? expected_port(st_x[i], st_y[i]) : -1;
          first     = 1'b0;
        end
        inject_packet(st_port[i], st_x[i], st_y[i], st_pay[i]);
        n_lines++;
        if (phase == 1) wait_drain();  // One packet at a time in an idle router
      end
    end
    if (phase == 3) begin
      #(CLK_PERIOD/4);
      check_value($sformatf("o_en[%0d] after DEPTH packets", bp_port), 0, o_en[bp_port]);
    end
    @(negedge clk);
    set_en(5'h1f);  // Release every output
    stress_mode = 1'b0;
    wait_drain();
    if (phase == 4) begin
      check_value("grants on contended output", n_lines, seen_src.size());
      for (int i = 1; i < seen_src.size(); i++) begin
        if (seen_src[i] == seen_src[i-1]) begin
          $display("Output %0d served port %0d twice in a row", watch_out, seen_src[i]);
          errors++;
          test_errors++;
        end
      end
    end
    finish_test(name);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    int    fd;
    int    n;
    int    ph;
    int    pt;
    int    x;
    int    y;
    int    pay;
    int    msk;
    string line;
    reset_n    = 1'b0;
    i_data     = '0;
    i_data_val = '0;
    i_en       = '1;
    fd = $fopen("router_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file router_stim.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        if (n > 0 && line.len() > 0 && line.substr(0, 0) != "#") begin  // Skip comments
          n = $sscanf(line, "%d %d %h %h %h %h", ph, pt, x, y, pay, msk);
          if (n == 6) begin
            st_phase.push_back(ph);
            st_port.push_back(pt);
            st_x.push_back(x);
            st_y.push_back(y);
            st_pay.push_back(pay);
            st_mask.push_back(msk);
          end
        end
      end
      $fclose(fd);
    end
    repeat (2) @(posedge clk);  // Two reset cycles
    @(negedge clk);
    reset_n = 1'b1;
    #(CLK_PERIOD/4);
    check_value("o_data_val after reset", 0, o_data_val);
    check_value("o_en after reset", 5'h1f, o_en);
    finish_test("reset");
    mon_on = 1'b1;
    run_phase(1, "latency");
    run_phase(2, "routing");
    run_phase(3, "backpressure");
    run_phase(4, "contention");
    run_phase(5, "random_en");
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) $display("Regression passed");
    else $display("Regression failed");
    $finish;
  end

endmodule

// ==== tb_router_assert.sv ====
`timescale 1ns/100ps

module tb_router_assert
  import noc_pkg::*;
(
  input logic                            clk,
  input logic                            reset_n,
  input logic [0:N_PORTS-1]              i_en,        // Downstream ready per output
  input logic [0:N_PORTS-1]              o_data_val,  // Output valids of the router
  input logic [0:N_PORTS-1][0:N_PORTS-1] i_grant      // [output][input] grants
);

  // --------------------------------------------------------------------------
  // Output handshake
  // --------------------------------------------------------------------------

  // A valid output is always a completed transfer
  a_val_needs_en: assert property (@(posedge clk) disable iff (!reset_n)
    (o_data_val & ~i_en) == '0)
    else $error("o_data_val high on an output whose i_en is low");

  // Quiet outputs once reset has taken effect
  a_quiet_in_reset: assert property (@(posedge clk)
    (!reset_n && $past(!reset_n)) |-> (o_data_val == '0))
    else $error("o_data_val high while reset_n is low");

  // --------------------------------------------------------------------------
  // Switch grants
  // --------------------------------------------------------------------------

  for (genvar o = 0; o < N_PORTS; o++) begin : g_grant
    // At most one input per output
    a_grant_onehot: assert property (@(posedge clk) disable iff (!reset_n)
      $onehot0(i_grant[o]))
      else $error("Grant word of output %0d has more than one bit set", o);
  end

endmodule

// ==== router_top.sv ====
`timescale 1ns/100ps

module router_top
  import noc_pkg::*;
#(
  parameter integer X_NODES = 4,  // Mesh columns
  parameter integer Y_NODES = 4,  // Mesh rows
  parameter integer X_LOC   = 2,  // Column of this router
  parameter integer Y_LOC   = 2,  // Row of this router
  parameter integer DEPTH   = 4   // Input queue depth
) (
  input  logic                  clk,
  input  logic                  reset_n,

  // --------------------------------------------------------------------------
  // Upstream bus, indexed by port_e
  // --------------------------------------------------------------------------
  input  packet_t [0:N_PORTS-1] i_data,      // Packets from upstream
  input  logic    [0:N_PORTS-1] i_data_val,  // Upstream packets valid
  output logic    [0:N_PORTS-1] o_en,        // Queue has room

  // --------------------------------------------------------------------------
  // Downstream bus, indexed by port_e
  // --------------------------------------------------------------------------
  output packet_t [0:N_PORTS-1] o_data,      // Packets to downstream
  output logic    [0:N_PORTS-1] o_data_val,  // Transfer happens this cycle
  input  logic    [0:N_PORTS-1] i_en         // Downstream has room
);

  packet_t [0:N_PORTS-1]              head_data;     // Queue heads into the crossbar
  logic    [0:N_PORTS-1]              head_val;      // Queue heads valid
  logic    [0:N_PORTS-1][0:N_PORTS-1] output_req;    // [input][output]
  logic    [0:N_PORTS-1][0:N_PORTS-1] output_grant;  // [output][input]
  logic    [0:N_PORTS-1]              deq_en;        // Dequeue per input

  // One queue and one route calculator per input port
  for (genvar p = 0; p < N_PORTS; p++) begin : g_port
    input_queue #(.DEPTH(DEPTH)) input_queue_i (
      .clk,
      .reset_n,
      .i_data     (i_data[p]),
      .i_data_val (i_data_val[p]),
      .o_en       (o_en[p]),
      .o_data     (head_data[p]),
      .o_data_val (head_val[p]),
      .i_en       (deq_en[p])          // From the grants
    );

    route_calc #(.X_NODES(X_NODES), .Y_NODES(Y_NODES), .X_LOC(X_LOC), .Y_LOC(Y_LOC))
      route_calc_i (
        .i_head       (head_data[p]),
        .i_val        (head_val[p]),
        .o_output_req (output_req[p])
      );
  end

  switch_control switch_control_i (
    .clk,
    .reset_n,
    .i_en           (i_en),
    .i_output_req   (output_req),
    .o_output_grant (output_grant)
  );

  crossbar crossbar_i (
    .i_sel  (output_grant),
    .i_data (head_data),
    .o_data (o_data)
  );

  // A queue is read when any output grants it
  always_comb begin
    deq_en = '0;
    for (int o = 0; o < N_PORTS; o++) begin
      deq_en |= output_grant[o];
    end
  end

  // Output valid whenever its grant word is non-zero
  always_comb begin
    for (int o = 0; o < N_PORTS; o++) begin
      o_data_val[o] = |output_grant[o];
    end
  end

endmodule

// ==== crossbar.sv ====
`timescale 1ns/100ps

module crossbar
  import noc_pkg::*;
(
  input  logic    [0:N_PORTS-1][0:N_PORTS-1] i_sel,   // [output][input] one-hot selects
  input  packet_t [0:N_PORTS-1]              i_data,  // Queue heads, one per input
  output packet_t [0:N_PORTS-1]              o_data   // Switched packets, one per output
);

  // --------------------------------------------------------------------------
  // AND-OR switch, one-hot select so at most one term per output
  // --------------------------------------------------------------------------

  always_comb begin
    o_data = '0;  // Unselected outputs stay at zero
    for (int o = 0; o < N_PORTS; o++) begin
      for (int i = 0; i < N_PORTS; i++) begin
        if (i_sel[o][i]) begin
          o_data[o] = o_data[o] | i_data[i];
        end
      end
    end
  end

endmodule

// ==== switch_control.sv ====
`timescale 1ns/100ps

module switch_control
  import noc_pkg::*;
(
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic [0:N_PORTS-1]               i_en,            // Downstream ready per output
  input  logic [0:N_PORTS-1][0:N_PORTS-1]  i_output_req,    // [input][output] requests
  output logic [0:N_PORTS-1][0:N_PORTS-1]  o_output_grant   // [output][input] one-hot grants
);

  typedef enum logic {
    IDLE,      // No grant in the last cycle
    GRANTING   // Last cycle carried a transfer
  } arb_state_e;

  arb_state_e         state_q   [N_PORTS];  // Per output arbiter state
  port_e              last_q    [N_PORTS];  // Input granted in the last cycle
  port_e              hold_q    [N_PORTS];  // Pointer kept through idle cycles
  port_e              rr_ptr    [N_PORTS];  // Current round-robin start
  port_e              grant_idx [N_PORTS];  // Input granted this cycle
  logic [0:N_PORTS-1] grant_any;            // Output transfers this cycle

  // Input after p, wrapping from west back to core
  function automatic port_e next_port(input port_e p);
    return (p == WEST) ? CORE : port_e'(int'(p) + 1);
  endfunction

  // --------------------------------------------------------------------------
  // Round-robin pointer
  // --------------------------------------------------------------------------

  // Moves past the last winner only after a grant, otherwise held
  always_comb begin
    for (int o = 0; o < N_PORTS; o++) begin
      rr_ptr[o] = (state_q[o] == GRANTING) ? next_port(last_q[o]) : hold_q[o];
    end
  end

  // --------------------------------------------------------------------------
  // Arbitration, one scan per output
  // --------------------------------------------------------------------------

  always_comb begin
    int   idx;
    logic found;
    o_output_grant = '0;
    for (int o = 0; o < N_PORTS; o++) begin
      grant_idx[o] = CORE;
      found        = 1'b0;
      idx          = int'(rr_ptr[o]);
      for (int k = 0; k < N_PORTS; k++) begin
        if (i_en[o] && !found && i_output_req[idx][o]) begin  // Blocked while downstream full
          o_output_grant[o][idx] = 1'b1;
          grant_idx[o]           = port_e'(idx);
          found                  = 1'b1;
        end
        idx = (idx == N_PORTS - 1) ? 0 : idx + 1;  // Next input in ring order
      end
      grant_any[o] = found;
    end
  end

  // Arbiter state per output
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int o = 0; o < N_PORTS; o++) begin
        state_q[o] <= IDLE;
        last_q[o]  <= CORE;
        hold_q[o]  <= CORE;   // All pointers start at core
      end
    end else begin
      for (int o = 0; o < N_PORTS; o++) begin
        state_q[o] <= grant_any[o] ? GRANTING : IDLE;
        hold_q[o]  <= rr_ptr[o];                // Freeze the pointer in use
        if (grant_any[o]) begin
          last_q[o] <= grant_idx[o];
        end
      end
    end
  end

endmodule

// ==== route_calc.sv ====
`timescale 1ns/100ps

module route_calc
  import noc_pkg::*;
#(
  parameter integer X_NODES = 4,  // Mesh columns
  parameter integer Y_NODES = 4,  // Mesh rows
  parameter integer X_LOC   = 0,  // Column of this router
  parameter integer Y_LOC   = 0   // Row of this router
) (
  input  packet_t            i_head,       // Head packet of the local queue
  input  logic               i_val,        // Head packet is valid
  output logic [0:N_PORTS-1] o_output_req  // One-hot output request
);

  logic  in_mesh;  // Destination lies inside the mesh
  port_e dir;      // Chosen output port

  // Range check against the mesh bounds
  assign in_mesh = (int'(i_head.x_dest) < X_NODES) &&
                   (int'(i_head.y_dest) < Y_NODES);

  // --------------------------------------------------------------------------
  // Dimension-order routing, X first then Y
  // --------------------------------------------------------------------------

  always_comb begin
    if (!in_mesh) begin
      dir = CORE;                                  // Stray packet goes to core
    end else if (int'(i_head.x_dest) > X_LOC) begin
      dir = EAST;
    end else if (int'(i_head.x_dest) < X_LOC) begin
      dir = WEST;
    end else if (int'(i_head.y_dest) > Y_LOC) begin
      dir = SOUTH;                                 // Column reached
    end else if (int'(i_head.y_dest) < Y_LOC) begin
      dir = NORTH;
    end else begin
      dir = CORE;                                  // Arrived at this node
    end
  end

  // No request without a valid head
  always_comb begin
    o_output_req      = '0;
    o_output_req[dir] = i_val;
  end

endmodule

// ==== input_queue.sv ====
`timescale 1ns/100ps

module input_queue
  import noc_pkg::*;
#(
  parameter integer DEPTH = 4  // Packets held per input port
) (
  input  logic    clk,
  input  logic    reset_n,

  // Upstream side
  input  packet_t i_data,      // Packet from the upstream router
  input  logic    i_data_val,  // Upstream packet is valid
  output logic    o_en,        // Room for one more packet

  // Switch side
  output packet_t o_data,      // Head of the queue
  output logic    o_data_val,  // Head is valid
  input  logic    i_en         // Head is taken this cycle
);

  localparam integer PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam integer CNT_W = $clog2(DEPTH + 1);

  packet_t          mem [DEPTH];  // Packet storage
  logic [PTR_W-1:0] wr_ptr;       // Next free slot
  logic [PTR_W-1:0] rd_ptr;       // Current head slot
  logic [CNT_W-1:0] count;        // Packets held
  logic             wr_fire;      // Upstream transfer completes
  logic             rd_fire;      // Head leaves through the switch

  // Circular increment, works for any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // --------------------------------------------------------------------------
  // Handshake on both sides
  // --------------------------------------------------------------------------

  assign o_en       = (count != CNT_W'(DEPTH));  // Not full, count only
  assign o_data_val = (count != '0);             // Not empty
  assign o_data     = mem[rd_ptr];

  assign wr_fire = i_data_val & o_en;
  assign rd_fire = i_en & o_data_val;

  // Pointers and fill level
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) wr_ptr <= ptr_inc(wr_ptr);
      if (rd_fire) rd_ptr <= ptr_inc(rd_ptr);
      case ({wr_fire, rd_fire})
        2'b10:   count <= count + 1'b1;  // Write only
        2'b01:   count <= count - 1'b1;  // Read only
        default: count <= count;         // Both or neither
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= i_data;
    end
  end

endmodule

// ==== noc_pkg.sv ====
package noc_pkg;

  // --------------------------------------------------------------------------
  // Router geometry and field widths
  // --------------------------------------------------------------------------

  localparam integer N_PORTS   = 5;   // Core plus four mesh directions
  localparam integer COORD_W   = 4;   // One mesh coordinate, meshes up to 16x16
  localparam integer PAYLOAD_W = 16;  // Payload carried with each packet

  // Port indices, fixed order as used on every request, grant and data vector
  typedef enum logic [2:0] {
    CORE  = 3'd0,  // Local processing element
    NORTH = 3'd1,  // Toward smaller y
    EAST  = 3'd2,  // Toward larger x
    SOUTH = 3'd3,  // Toward larger y
    WEST  = 3'd4   // Toward smaller x
  } port_e;

  // --------------------------------------------------------------------------
  // Packet format
  // --------------------------------------------------------------------------

  // One flit per packet, the whole packet moves in a single transfer
  typedef struct packed {
    logic [COORD_W-1:0]   x_dest;    // Destination column
    logic [COORD_W-1:0]   y_dest;    // Destination row
    port_e                src_port;  // Port where the packet entered this router
    logic [PAYLOAD_W-1:0] payload;   // User data, passed through untouched
  } packet_t;

endpackage
